/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] xlen_t;

   // Major opcodes of the supported groups
   typedef enum logic [6:0] {
      OP_LUI    = 7'b0110111,
      OP_AUIPC  = 7'b0010111,
      OP_JAL    = 7'b1101111,
      OP_JALR   = 7'b1100111,
      OP_BRANCH = 7'b1100011,
      OP_LOAD   = 7'b0000011,
      OP_STORE  = 7'b0100011,
      OP_IMM    = 7'b0010011,
      OP_REG    = 7'b0110011
   } opcode_t;

   ////////////////////////////////////////////////////////////
   // funct3 and funct7 fields
   ////////////////////////////////////////////////////////////

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SR      = 3'b101;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   // Only word loads and stores
   localparam logic [2:0] F3_WORD = 3'b010;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;

   // addi x0, x0, 0
   localparam xlen_t NOP_INSTR = 32'h0000_0013;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLL,
      ALU_SRL, ALU_SRA, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
   } alu_op_t;

   typedef enum logic [1:0] {
      MEM_NOP,
      MEM_LW,
      MEM_SW
   } mem_op_t;

endpackage

/* verilog/core_ctrl_pkg.sv */
package core_ctrl_pkg;

   typedef enum logic [3:0] {
      PC_FETCH,
      INST_DEC,
      READ_REGS,
      ALU_START,
      ALU_WAIT,
      MEM_OP,
      WRITEBACK,
      NEXT_PC,
      NEXT_PC_WAIT
   } stage_t;

   // Register write-back source
   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_PC4,
      WB_IMM
   } wb_sel_t;

   typedef struct packed {
      logic [4:0]          rs1;
      logic [4:0]          rs2;
      logic [4:0]          rd;
      rv_isa_pkg::alu_op_t alu_op;
      logic                pc_op;
      logic                imm_op;
      rv_isa_pkg::mem_op_t mem_op;
      logic                reg_write;
      wb_sel_t             wb_sel;
      logic                jal;
      logic                jalr;
      logic                branch;
      logic                invalid;
   } ctrl_t;

   localparam rv_isa_pkg::xlen_t RESET_PC    = 32'h8000_0000;
   localparam rv_isa_pkg::xlen_t TRAP_VECTOR = 32'h8000_0100;

   // mcause style codes
   localparam logic [3:0] CAUSE_MISALIGNED_FETCH = 4'd0;
   localparam logic [3:0] CAUSE_ILLEGAL          = 4'd2;
   localparam logic [3:0] CAUSE_MISALIGNED_LOAD  = 4'd4;
   localparam logic [3:0] CAUSE_MISALIGNED_STORE = 4'd6;

endpackage

/* verilog/alu_if.sv */
interface alu_if;

   logic                start;
   rv_isa_pkg::alu_op_t op;
   rv_isa_pkg::xlen_t   a;
   rv_isa_pkg::xlen_t   b;
   rv_isa_pkg::xlen_t   result;
   logic                done;

   modport master (output start, op, a, b, input result, done);
   modport slave (input start, op, a, b, output result, done);

endinterface

/* verilog/instr_decoder.sv */
module instr_decoder (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 load_i,
   input  rv_isa_pkg::xlen_t    instr_i,
   output core_ctrl_pkg::ctrl_t ctrl_o,
   output rv_isa_pkg::xlen_t    imm_o
);

   rv_isa_pkg::xlen_t instr_q;
   logic [2:0]        f3;
   logic [6:0]        f7;
   logic              needs_f7;
   logic              f7_ok;

   function automatic rv_isa_pkg::alu_op_t arith_op(input logic [2:0] f3_i, input logic alt_i);
      arith_op = rv_isa_pkg::ALU_ADD;
      case (f3_i)
         rv_isa_pkg::F3_ADD_SUB: arith_op = alt_i ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
         rv_isa_pkg::F3_SLL:     arith_op = rv_isa_pkg::ALU_SLL;
         rv_isa_pkg::F3_SLT:     arith_op = rv_isa_pkg::ALU_SLT;
         rv_isa_pkg::F3_SLTU:    arith_op = rv_isa_pkg::ALU_SLTU;
         rv_isa_pkg::F3_XOR:     arith_op = rv_isa_pkg::ALU_XOR;
         rv_isa_pkg::F3_SR:      arith_op = alt_i ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
         rv_isa_pkg::F3_OR:      arith_op = rv_isa_pkg::ALU_OR;
         rv_isa_pkg::F3_AND:     arith_op = rv_isa_pkg::ALU_AND;
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         instr_q <= rv_isa_pkg::NOP_INSTR;
      end else if (load_i) begin
         instr_q <= instr_i;
      end
   end

   assign f3 = instr_q[14:12];
   assign f7 = instr_q[31:25];

   // In OP-IMM the upper bits only matter for shifts
   assign needs_f7 = (instr_q[6:0] == rv_isa_pkg::OP_REG) ||
                     (f3 == rv_isa_pkg::F3_SLL) || (f3 == rv_isa_pkg::F3_SR);
   assign f7_ok = !needs_f7 || (f7 == rv_isa_pkg::F7_BASE) ||
                  ((f7 == rv_isa_pkg::F7_ALT) && ((f3 == rv_isa_pkg::F3_SR) ||
                   ((f3 == rv_isa_pkg::F3_ADD_SUB) && (instr_q[6:0] == rv_isa_pkg::OP_REG))));

   always_comb begin
      ctrl_o.rs1       = instr_q[19:15];
      ctrl_o.rs2       = instr_q[24:20];
      ctrl_o.rd        = instr_q[11:7];
      ctrl_o.alu_op    = rv_isa_pkg::ALU_ADD;
      ctrl_o.pc_op     = 1'b0;
      ctrl_o.imm_op    = 1'b1;
      ctrl_o.mem_op    = rv_isa_pkg::MEM_NOP;
      ctrl_o.reg_write = 1'b0;
      ctrl_o.wb_sel    = core_ctrl_pkg::WB_ALU;
      ctrl_o.jal       = 1'b0;
      ctrl_o.jalr      = 1'b0;
      ctrl_o.branch    = 1'b0;
      ctrl_o.invalid   = 1'b0;
      // I-type unless the opcode says otherwise
      imm_o = {{20{instr_q[31]}}, instr_q[31:20]};

      case (rv_isa_pkg::opcode_t'(instr_q[6:0]))
         rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: begin
            imm_o            = {instr_q[31:12], 12'b0};
            ctrl_o.pc_op     = 1'b1;
            ctrl_o.reg_write = 1'b1;
            if (instr_q[5]) begin
               ctrl_o.wb_sel = core_ctrl_pkg::WB_IMM;
            end
         end
         rv_isa_pkg::OP_JAL: begin
            imm_o = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                     instr_q[30:21], 1'b0};
            ctrl_o.pc_op     = 1'b1;
            ctrl_o.jal       = 1'b1;
            ctrl_o.reg_write = 1'b1;
            ctrl_o.wb_sel    = core_ctrl_pkg::WB_PC4;
         end
         rv_isa_pkg::OP_JALR: begin
            ctrl_o.jalr      = 1'b1;
            ctrl_o.reg_write = 1'b1;
            ctrl_o.wb_sel    = core_ctrl_pkg::WB_PC4;
            ctrl_o.invalid   = f3 != 3'b000;
         end
         rv_isa_pkg::OP_BRANCH: begin
            imm_o = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                     instr_q[11:8], 1'b0};
            ctrl_o.imm_op = 1'b0;
            ctrl_o.branch = 1'b1;
            case (f3)
               rv_isa_pkg::F3_BEQ:  ctrl_o.alu_op = rv_isa_pkg::ALU_EQ;
               rv_isa_pkg::F3_BNE:  ctrl_o.alu_op = rv_isa_pkg::ALU_NE;
               rv_isa_pkg::F3_BLT:  ctrl_o.alu_op = rv_isa_pkg::ALU_LT;
               rv_isa_pkg::F3_BGE:  ctrl_o.alu_op = rv_isa_pkg::ALU_GE;
               rv_isa_pkg::F3_BLTU: ctrl_o.alu_op = rv_isa_pkg::ALU_LTU;
               rv_isa_pkg::F3_BGEU: ctrl_o.alu_op = rv_isa_pkg::ALU_GEU;
               default:             ctrl_o.invalid = 1'b1;
            endcase
         end
         rv_isa_pkg::OP_LOAD: begin
            ctrl_o.mem_op    = rv_isa_pkg::MEM_LW;
            ctrl_o.reg_write = 1'b1;
            ctrl_o.wb_sel    = core_ctrl_pkg::WB_MEM;
            ctrl_o.invalid   = f3 != rv_isa_pkg::F3_WORD;
         end
         rv_isa_pkg::OP_STORE: begin
            imm_o          = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
            ctrl_o.mem_op  = rv_isa_pkg::MEM_SW;
            ctrl_o.invalid = f3 != rv_isa_pkg::F3_WORD;
         end
         rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_REG: begin
            ctrl_o.imm_op    = !instr_q[5];
            ctrl_o.reg_write = 1'b1;
            ctrl_o.alu_op    = arith_op(f3, needs_f7 && (f7 == rv_isa_pkg::F7_ALT));
            ctrl_o.invalid   = !f7_ok;
         end
         default: ctrl_o.invalid = 1'b1;
      endcase
   end

endmodule

/* verilog/reg_file.sv */
module reg_file (
   input  logic              clk,
   input  logic [4:0]        rs1_i,
   input  logic [4:0]        rs2_i,
   input  logic [4:0]        rd_i,
   input  logic              we_i,
   input  rv_isa_pkg::xlen_t wdata_i,
   output rv_isa_pkg::xlen_t rdata1_o,
   output rv_isa_pkg::xlen_t rdata2_o
);

   rv_isa_pkg::xlen_t regs [32];

   always_ff @(posedge clk) begin
      if (we_i && (rd_i != 5'd0)) begin
         regs[rd_i] <= wdata_i;
      end
   end

   // x0 reads as zero whatever the array holds
   assign rdata1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
   assign rdata2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

/* verilog/seq_alu.sv */
module seq_alu (
   input logic  clk,
   input logic  rst,
   alu_if.slave alu
);

   rv_isa_pkg::xlen_t   acc_q;
   rv_isa_pkg::xlen_t   quick;
   rv_isa_pkg::alu_op_t op_q;
   logic [4:0]          count_q;
   logic                busy_q;
   logic                is_shift;

   assign is_shift = alu.op inside {rv_isa_pkg::ALU_SLL, rv_isa_pkg::ALU_SRL,
                                    rv_isa_pkg::ALU_SRA};

   assign alu.result = acc_q;
   assign alu.done   = busy_q && (count_q == 5'd0);

   // Single-cycle operations
   always_comb begin
      case (alu.op)
         rv_isa_pkg::ALU_SUB: quick = alu.a - alu.b;
         rv_isa_pkg::ALU_AND: quick = alu.a & alu.b;
         rv_isa_pkg::ALU_OR:  quick = alu.a | alu.b;
         rv_isa_pkg::ALU_XOR: quick = alu.a ^ alu.b;
         rv_isa_pkg::ALU_EQ:  quick = 32'(alu.a == alu.b);
         rv_isa_pkg::ALU_NE:  quick = 32'(alu.a != alu.b);
         rv_isa_pkg::ALU_SLT, rv_isa_pkg::ALU_LT: quick = 32'($signed(alu.a) < $signed(alu.b));
         rv_isa_pkg::ALU_GE:  quick = 32'($signed(alu.a) >= $signed(alu.b));
         rv_isa_pkg::ALU_SLTU, rv_isa_pkg::ALU_LTU: quick = 32'(alu.a < alu.b);
         rv_isa_pkg::ALU_GEU: quick = 32'(alu.a >= alu.b);
         default:             quick = alu.a + alu.b;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Shift one bit per cycle until the count runs out
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         busy_q  <= 1'b0;
         count_q <= 5'd0;
      end else if (alu.start) begin
         busy_q  <= 1'b1;
         count_q <= is_shift ? alu.b[4:0] : 5'd0;
      end else if (busy_q) begin
         if (count_q == 5'd0) begin
            busy_q <= 1'b0;
         end else begin
            count_q <= count_q - 5'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (alu.start) begin
         acc_q <= is_shift ? alu.a : quick;
         op_q  <= alu.op;
      end else if (busy_q && (count_q != 5'd0)) begin
         case (op_q)
            rv_isa_pkg::ALU_SLL: acc_q <= acc_q << 1;
            rv_isa_pkg::ALU_SRL: acc_q <= acc_q >> 1;
            default:             acc_q <= {acc_q[31], acc_q[31:1]};
         endcase
      end
   end

endmodule

/* verilog/exc_detect.sv */
module exc_detect (
   input  core_ctrl_pkg::ctrl_t ctrl_i,
   input  rv_isa_pkg::xlen_t    data_addr_i,
   input  rv_isa_pkg::xlen_t    jump_dst_i,
   input  logic                 jump_i,
   output logic                 exc_o,
   output logic [3:0]           cause_o
);

   logic data_misaligned;
   logic jump_misaligned;

   assign data_misaligned = (ctrl_i.mem_op != rv_isa_pkg::MEM_NOP) &&
                            (data_addr_i[1:0] != 2'b00);
   assign jump_misaligned = jump_i && (jump_dst_i[1:0] != 2'b00);

   assign exc_o = ctrl_i.invalid || data_misaligned || jump_misaligned;

   // Illegal first, then data address, then jump target
   always_comb begin
      if (ctrl_i.invalid) begin
         cause_o = core_ctrl_pkg::CAUSE_ILLEGAL;
      end else if (data_misaligned) begin
         cause_o = (ctrl_i.mem_op == rv_isa_pkg::MEM_LW) ?
                   core_ctrl_pkg::CAUSE_MISALIGNED_LOAD : core_ctrl_pkg::CAUSE_MISALIGNED_STORE;
      end else begin
         cause_o = core_ctrl_pkg::CAUSE_MISALIGNED_FETCH;
      end
   end

endmodule

/* verilog/multicycle_core.sv */
module multicycle_core (
   input  logic                clk,
   input  logic                rst,
   output rv_isa_pkg::mem_op_t mem_op_o,
   output rv_isa_pkg::xlen_t   addr_o,
   output rv_isa_pkg::xlen_t   wdata_o,
   input  rv_isa_pkg::xlen_t   rdata_i,
   output rv_isa_pkg::xlen_t   pc_o,
   output logic                exception_o,
   output logic [3:0]          exc_cause_o
);

   core_ctrl_pkg::stage_t stage_q;
   core_ctrl_pkg::stage_t stage_d;
   core_ctrl_pkg::ctrl_t  ctrl;
   rv_isa_pkg::xlen_t     pc_q;
   rv_isa_pkg::xlen_t     pc_d;
   rv_isa_pkg::xlen_t     imm;
   rv_isa_pkg::xlen_t     rs1_data;
   rv_isa_pkg::xlen_t     rs2_data;
   rv_isa_pkg::xlen_t     wb_data;
   rv_isa_pkg::xlen_t     jump_dst;
   logic                  rf_we;
   logic                  exc;
   logic                  jump;
   logic                  branch_taken;
   logic                  branch_q;

   alu_if alu_bus ();

   assign pc_o = pc_q;

   instr_decoder u_decoder (
      .clk,
      .rst,
      .load_i  (stage_q == core_ctrl_pkg::INST_DEC),
      .instr_i (rdata_i),
      .ctrl_o  (ctrl),
      .imm_o   (imm)
   );

   reg_file u_regs (
      .clk,
      .rs1_i    (ctrl.rs1),
      .rs2_i    (ctrl.rs2),
      .rd_i     (ctrl.rd),
      .we_i     (rf_we),
      .wdata_i  (wb_data),
      .rdata1_o (rs1_data),
      .rdata2_o (rs2_data)
   );

   seq_alu u_alu (
      .clk,
      .rst,
      .alu (alu_bus)
   );

   // Compare result sits in bit zero until the PC add starts
   assign branch_taken = ctrl.branch && alu_bus.result[0];
   assign jump = ctrl.jal || ctrl.jalr || ((stage_q == core_ctrl_pkg::NEXT_PC_WAIT) && branch_q);
   assign jump_dst = ctrl.jalr ? {alu_bus.result[31:1], 1'b0} : alu_bus.result;

   exc_detect u_exc (
      .ctrl_i      (ctrl),
      .data_addr_i (alu_bus.result),
      .jump_dst_i  (jump_dst),
      .jump_i      (jump),
      .exc_o       (exc),
      .cause_o     (exc_cause_o)
   );

   always_comb begin
      case (ctrl.wb_sel)
         core_ctrl_pkg::WB_MEM: wb_data = rdata_i;
         core_ctrl_pkg::WB_PC4: wb_data = pc_q + 32'd4;
         core_ctrl_pkg::WB_IMM: wb_data = imm;
         default:               wb_data = alu_bus.result;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         stage_q  <= core_ctrl_pkg::PC_FETCH;
         pc_q     <= core_ctrl_pkg::RESET_PC;
         branch_q <= 1'b0;
      end else begin
         stage_q <= stage_d;
         if (stage_d == core_ctrl_pkg::PC_FETCH) begin
            pc_q <= pc_d;
         end
         if (stage_q == core_ctrl_pkg::NEXT_PC) begin
            branch_q <= branch_taken;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Stage sequencer
   ////////////////////////////////////////////////////////////

   always_comb begin
      stage_d       = stage_q;
      pc_d          = pc_q;
      mem_op_o      = rv_isa_pkg::MEM_NOP;
      addr_o        = pc_q;
      wdata_o       = '0;
      rf_we         = 1'b0;
      exception_o   = 1'b0;
      alu_bus.start = 1'b0;
      alu_bus.op    = ctrl.alu_op;
      alu_bus.a     = ctrl.pc_op ? pc_q : rs1_data;
      alu_bus.b     = ctrl.imm_op ? imm : rs2_data;

      case (stage_q)
         // Address set up one cycle ahead of the read
         core_ctrl_pkg::PC_FETCH: stage_d = core_ctrl_pkg::INST_DEC;
         core_ctrl_pkg::INST_DEC: begin
            mem_op_o = rv_isa_pkg::MEM_LW;
            stage_d  = core_ctrl_pkg::READ_REGS;
         end
         core_ctrl_pkg::READ_REGS: begin
            stage_d = ctrl.invalid ? core_ctrl_pkg::NEXT_PC : core_ctrl_pkg::ALU_START;
         end
         core_ctrl_pkg::ALU_START: begin
            alu_bus.start = 1'b1;
            stage_d       = core_ctrl_pkg::ALU_WAIT;
         end
         core_ctrl_pkg::ALU_WAIT: begin
            if (alu_bus.done) begin
               stage_d = core_ctrl_pkg::MEM_OP;
            end
         end
         core_ctrl_pkg::MEM_OP: begin
            addr_o  = alu_bus.result;
            wdata_o = rs2_data;
            // A faulting access never reaches memory
            if (!exc) begin
               mem_op_o = ctrl.mem_op;
            end
            stage_d = (ctrl.reg_write && !exc) ? core_ctrl_pkg::WRITEBACK : core_ctrl_pkg::NEXT_PC;
         end
         core_ctrl_pkg::WRITEBACK: begin
            addr_o  = alu_bus.result;
            rf_we   = ctrl.reg_write && !exc;
            stage_d = core_ctrl_pkg::NEXT_PC;
         end
         core_ctrl_pkg::NEXT_PC: begin
            alu_bus.op = rv_isa_pkg::ALU_ADD;
            alu_bus.a  = pc_q;
            alu_bus.b  = branch_taken ? imm : 32'd4;
            if (exc) begin
               exception_o = 1'b1;
               pc_d        = core_ctrl_pkg::TRAP_VECTOR;
               stage_d     = core_ctrl_pkg::PC_FETCH;
            end else if (ctrl.jal || ctrl.jalr) begin
               pc_d    = jump_dst;
               stage_d = core_ctrl_pkg::PC_FETCH;
            end else begin
               alu_bus.start = 1'b1;
               stage_d       = core_ctrl_pkg::NEXT_PC_WAIT;
            end
         end
         core_ctrl_pkg::NEXT_PC_WAIT: begin
            if (alu_bus.done) begin
               stage_d = core_ctrl_pkg::PC_FETCH;
               pc_d    = alu_bus.result;
               // Taken branch landing off a word boundary
               if (exc) begin
                  exception_o = 1'b1;
                  pc_d        = core_ctrl_pkg::TRAP_VECTOR;
               end
            end
         end
         default: stage_d = core_ctrl_pkg::PC_FETCH;
      endcase
   end

endmodule

/* bench/core_checker.sv */
module core_checker (
   input  logic                clk,
   input  logic                rst,
   input  rv_isa_pkg::mem_op_t mem_op_i,
   input  rv_isa_pkg::xlen_t   addr_i,
   input  rv_isa_pkg::xlen_t   wdata_i,
   input  rv_isa_pkg::xlen_t   pc_i,
   input  logic                exception_i,
   input  logic [3:0]          cause_i,
   output int                  errors_o,
   output logic                complete_o,
   output int                  stores_seen_o,
   output int                  stores_exp_o,
   output int                  traps_seen_o,
   output int                  traps_exp_o
);

   localparam int PAT_WORDS  = 512;
   localparam int STORE_BASE = 'h110;
   localparam int TRAP_BASE  = 'h180;

   localparam rv_isa_pkg::xlen_t FIRST_FETCH = 32'h8000_0000;
   localparam rv_isa_pkg::xlen_t TRAP_ADDR   = 32'h8000_0100;

   rv_isa_pkg::xlen_t pat [PAT_WORDS];

   int   err_count    = 0;
   int   store_idx    = 0;
   int   trap_idx     = 0;
   logic fetch_seen   = 1'b0;
   logic trap_pending = 1'b0;

   initial begin
      for (int i = 0; i < PAT_WORDS; i++) begin
         pat[i] = 32'hBAD1_0000 | i;
      end
      $readmemh("bench/core_patterns.txt", pat);
   end

   assign stores_exp_o  = int'(pat[1]);
   assign traps_exp_o   = int'(pat[2]);
   assign stores_seen_o = store_idx;
   assign traps_seen_o  = trap_idx;
   assign errors_o      = err_count;
   assign complete_o    = (store_idx >= stores_exp_o) && (trap_idx >= traps_exp_o) &&
                          !trap_pending;

   task automatic check_value(input string name, input rv_isa_pkg::xlen_t exp,
                              input rv_isa_pkg::xlen_t got);
      if (got !== exp) begin
         $display("[FAIL] %s expected %h got %h", name, exp, got);
         err_count++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Sampled on the falling edge, away from DUT updates
   ////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (rst) begin
         check_value("mem_op_o", 32'(rv_isa_pkg::MEM_NOP), 32'(mem_op_i));
      end else begin
         if (!fetch_seen && (mem_op_i != rv_isa_pkg::MEM_NOP)) begin
            fetch_seen = 1'b1;
            check_value("mem_op_o", 32'(rv_isa_pkg::MEM_LW), 32'(mem_op_i));
            check_value("addr_o", FIRST_FETCH, addr_i);
         end
         // Trap target shows up one cycle after the pulse
         if (trap_pending) begin
            trap_pending = 1'b0;
            check_value("pc_o", TRAP_ADDR, pc_i);
         end
         if (mem_op_i == rv_isa_pkg::MEM_SW) begin
            if (store_idx < stores_exp_o) begin
               check_value("addr_o", pat[STORE_BASE + 2 * store_idx], addr_i);
               check_value("wdata_o", pat[STORE_BASE + 2 * store_idx + 1], wdata_i);
            end else begin
               $display("Store to %h with data %h came after the expected list ran out",
                        addr_i, wdata_i);
               err_count++;
            end
            store_idx++;
         end
         if (exception_i) begin
            if (trap_idx < traps_exp_o) begin
               check_value("pc_o", pat[TRAP_BASE + 2 * trap_idx], pc_i);
               check_value("exc_cause_o", pat[TRAP_BASE + 2 * trap_idx + 1], 32'(cause_i));
            end else begin
               $display("Exception at pc %h was not expected", pc_i);
               err_count++;
            end
            trap_idx++;
            trap_pending = 1'b1;
         end
      end
   end

endmodule

/* bench/core_tb.sv */
module core_tb;

   localparam int PAT_WORDS  = 512;
   localparam int MEM_WORDS  = 256;
   localparam int IMAGE_BASE = 'h10;

   logic                clk;
   logic                rst;
   rv_isa_pkg::mem_op_t mem_op;
   rv_isa_pkg::xlen_t   addr;
   rv_isa_pkg::xlen_t   wdata;
   rv_isa_pkg::xlen_t   rdata;
   rv_isa_pkg::xlen_t   pc;
   logic                exception;
   logic [3:0]          exc_cause;

   rv_isa_pkg::xlen_t pat [PAT_WORDS];
   rv_isa_pkg::xlen_t mem [MEM_WORDS];

   int   errors;
   logic complete;
   int   stores_seen;
   int   stores_exp;
   int   traps_seen;
   int   traps_exp;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
   end

   multicycle_core multicycle_core_i (
      .clk,
      .rst,
      .mem_op_o    (mem_op),
      .addr_o      (addr),
      .wdata_o     (wdata),
      .rdata_i     (rdata),
      .pc_o        (pc),
      .exception_o (exception),
      .exc_cause_o (exc_cause)
   );

   core_checker checker_i (
      .clk,
      .rst,
      .mem_op_i      (mem_op),
      .addr_i        (addr),
      .wdata_i       (wdata),
      .pc_i          (pc),
      .exception_i   (exception),
      .cause_i       (exc_cause),
      .errors_o      (errors),
      .complete_o    (complete),
      .stores_seen_o (stores_seen),
      .stores_exp_o  (stores_exp),
      .traps_seen_o  (traps_seen),
      .traps_exp_o   (traps_exp)
   );

   ////////////////////////////////////////////////////////////
   // Word-addressed memory, combinational read
   ////////////////////////////////////////////////////////////

   assign rdata = mem[addr[9:2]];

   always @(posedge clk) begin
      if (mem_op == rv_isa_pkg::MEM_SW) begin
         mem[addr[9:2]] <= wdata;
      end
   end

   initial begin
      int cycles;
      int limit;
      logic timed_out;
      for (int i = 0; i < PAT_WORDS; i++) begin
         pat[i] = 32'hBAD0_0000 | i;
      end
      $readmemh("bench/core_patterns.txt", pat);
      // Image words sit at a fixed offset in the patterns file
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = pat[IMAGE_BASE + i];
      end
      limit = 64 * int'(pat[0]);
      cycles = 0;
      timed_out = 1'b0;
      @(negedge rst);
      while (!complete && (cycles < limit)) begin
         @(posedge clk);
         cycles++;
      end
      if (!complete) begin
         timed_out = 1'b1;
         $display("Run timed out after %0d cycles with %0d of %0d stores and %0d of %0d traps",
                  cycles, stores_seen, stores_exp, traps_seen, traps_exp);
      end
      $display("Checks done: %0d errors, %0d stores, %0d traps, %0d cycles",
               errors + int'(timed_out), stores_seen, traps_seen, cycles);
      if ((errors == 0) && !timed_out) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* bench/core_patterns.txt */
// @000 counts: program words, store records, trap records
// @010 program image from 80000000, @110 store pairs (addr data), @180 trap pairs (pc cause)
@000
00000037 00000012 00000002
@010
800000B7 20008093 06400113 FF900193 00310233 0040A023 402182B3 0050A223
0021A333 0021B3B3 0060A423 0070A623 0F01C413 7FF47493 0104E493 0090A823
12345537 00A0AA23 00001597 00B0AC23 80000637 01160613 00061693 00D0AE23
00165713 02E0A023 41F65793 02F0A223 01F61813 0300A423 00310463 0220A623
0021C463 0200A823 0230A823 00C008EF 0200A823 0200A823 0310AA23 01888967
0200A823 0200A823 0320AC23 0140A983 0330AE23 00000B13 00000A97 FFFFFFFF
0560A023 00000A97 0020A123 0560A223 0000006F
// Trap handler at 80000100
@050
001B0B13 008A8067
@110
80000200 0000005D
80000204 FFFFFF95
80000208 00000001
8000020C 00000000
80000210 00000719
80000214 12345000
80000218 80001048
8000021C 80000011
80000220 40000008
80000224 FFFFFFFF
80000228 80000000
8000022C 00000064
80000230 FFFFFFF9
80000234 80000090
80000238 800000A0
8000023C 12345000
80000240 00000001
80000244 00000002
@180
800000BC 00000002
800000C8 00000006

/* flist.f */
verilog/rv_isa_pkg.sv
verilog/core_ctrl_pkg.sv
verilog/alu_if.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/seq_alu.sv
verilog/exc_detect.sv
verilog/multicycle_core.sv
bench/core_checker.sv
bench/core_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module core_tb -o core_sim

out=$(./obj_dir/core_sim)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
   exit 0
else
   exit 1
fi
